// File: Makefile
VERILATOR ?= verilator
TOP       ?= mipsControlTb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_FLAGS ?= +verilator+error+limit+100
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/controlWordGen.sv
`timescale 1ns/10ps

module controlWordGen import ctrlPkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  step_t         step,
    input  decodedInstr_t decoded,
    output ctrlWord_t     ctrl,
    output busReq_t       bus
);

    ctrlWord_t nextCtrl;
    busReq_t   nextBus;

    always_comb begin
        nextCtrl = '0;
        nextBus  = '0;
        case (step)
            StepInit: begin
                // Stack pointer setup
                nextCtrl.regWrite = 1'b1;
                nextCtrl.regDst   = DstStackPtr;
                nextCtrl.dataSrc  = DataStackInit;
            end
            StepFetchBus: begin
                nextBus.cyc       = 1'b1;
                nextBus.stb       = 1'b1;
                nextCtrl.iorD     = IorDPc;
                nextCtrl.aluOp    = AluAdd;
                nextCtrl.aluSrcA  = SrcAPc;
                nextCtrl.aluSrcB  = SrcBFour;
                nextCtrl.pcSource = PcSrcAluResult;
            end
            StepIrLoad: begin
                // PC plus four still on the ALU output
                nextCtrl.irWrite  = 1'b1;
                nextCtrl.pcWrite  = 1'b1;
                nextCtrl.aluOp    = AluAdd;
                nextCtrl.aluSrcA  = SrcAPc;
                nextCtrl.aluSrcB  = SrcBFour;
                nextCtrl.pcSource = PcSrcAluResult;
            end
            StepDecode: begin
                nextCtrl.regAWrite   = 1'b1;
                nextCtrl.regBWrite   = 1'b1;
                nextCtrl.aluOutWrite = 1'b1;
                nextCtrl.aluOp       = AluAdd;
                nextCtrl.aluSrcA     = SrcAPc;
                nextCtrl.aluSrcB     = SrcBShiftedImm;
            end
            StepAddrCalc: begin
                nextCtrl.aluOutWrite = 1'b1;
                nextCtrl.aluOp       = AluAdd;
                nextCtrl.aluSrcA     = SrcARegA;
                nextCtrl.aluSrcB     = SrcBSignImm;
            end
            StepDataRead: begin
                nextBus.cyc   = 1'b1;
                nextBus.stb   = 1'b1;
                nextCtrl.iorD = IorDAluOut;
            end
            StepDataWrite: begin
                nextBus.cyc        = 1'b1;
                nextBus.stb        = 1'b1;
                nextBus.we         = 1'b1;
                nextCtrl.iorD      = IorDAluOut;
                nextCtrl.storeSize = decoded.size;
            end
            StepWriteback: begin
                nextCtrl.regWrite = 1'b1;
                nextCtrl.regDst   = DstRt;
                if (decoded.cls == ClassLui) begin
                    nextCtrl.dataSrc = DataUpperImm;
                end else begin
                    nextCtrl.dataSrc  = DataMemory;
                    nextCtrl.loadSize = decoded.size;
                end
            end
            StepBreakCalc,
            StepBreakPc: begin
                // Rewind to the break instruction
                nextCtrl.pcWrite  = (step == StepBreakPc);
                nextCtrl.aluOp    = AluSub;
                nextCtrl.aluSrcA  = SrcAPc;
                nextCtrl.aluSrcB  = SrcBFour;
                nextCtrl.pcSource = PcSrcAluResult;
            end
            default: begin
                nextCtrl = '0;
                nextBus  = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl <= '0;
            bus  <= '0;
        end else begin
            ctrl <= nextCtrl;
            bus  <= nextBus;
        end
    end

endmodule

// File: design/ctrlPkg.sv
package ctrlPkg;

    localparam int OpcodeWidth = 6;
    localparam int FunctWidth  = 6;

    typedef logic [OpcodeWidth-1:0] opcode_t;
    typedef logic [FunctWidth-1:0]  funct_t;

    // Opcodes of the kept instructions
    localparam opcode_t OpRType = 6'b000000;
    localparam opcode_t OpLw    = 6'b100011;
    localparam opcode_t OpLh    = 6'b100001;
    localparam opcode_t OpLb    = 6'b100000;
    localparam opcode_t OpSw    = 6'b101011;
    localparam opcode_t OpSh    = 6'b101001;
    localparam opcode_t OpSb    = 6'b101000;
    localparam opcode_t OpLui   = 6'b001111;

    localparam funct_t FunctBreak = 6'b001101;

    typedef enum logic [2:0] {
        ClassLoad,
        ClassStore,
        ClassLui,
        ClassBreak,
        ClassUnknown
    } instrClass_t;

    // Same code for load extract and store merge width
    typedef enum logic [1:0] {
        SizeNone = 2'b00,
        SizeWord = 2'b01,
        SizeByte = 2'b10,
        SizeHalf = 2'b11
    } memSize_t;

    typedef struct packed {
        instrClass_t cls;
        memSize_t    size;
    } decodedInstr_t;

    typedef enum logic [3:0] {
        StepInit,
        StepFetchBus,
        StepIrLoad,
        StepDecode,
        StepAddrCalc,
        StepDataRead,
        StepDataWrite,
        StepWriteback,
        StepBreakCalc,
        StepBreakPc
    } step_t;

    typedef enum logic [2:0] {AluLoad = 3'b000, AluAdd = 3'b001, AluSub = 3'b010} aluOp_t;
    typedef enum logic [1:0] {SrcAPc = 2'b01, SrcARegA = 2'b10} aluSrcA_t;
    typedef enum logic [1:0] {
        SrcBRegB = 2'b00, SrcBFour = 2'b01, SrcBSignImm = 2'b10, SrcBShiftedImm = 2'b11
    } aluSrcB_t;
    typedef enum logic [2:0] {IorDPc = 3'b000, IorDAluOut = 3'b110} iorD_t;
    typedef enum logic [1:0] {PcSrcAluOut = 2'b00, PcSrcAluResult = 2'b01} pcSource_t;
    typedef enum logic [1:0] {DstStackPtr = 2'b00, DstRt = 2'b01, DstRd = 2'b10} regDst_t;
    typedef enum logic [2:0] {
        DataAluOut = 3'b000, DataStackInit = 3'b100, DataUpperImm = 3'b101, DataMemory = 3'b111
    } dataSrc_t;

    typedef struct packed {
        logic      pcWrite;
        pcSource_t pcSource;
        logic      irWrite;
        iorD_t     iorD;
        logic      regAWrite;
        logic      regBWrite;
        logic      aluOutWrite;
        aluOp_t    aluOp;
        aluSrcA_t  aluSrcA;
        aluSrcB_t  aluSrcB;
        logic      regWrite;
        regDst_t   regDst;
        dataSrc_t  dataSrc;
        memSize_t  storeSize;
        memSize_t  loadSize;
    } ctrlWord_t;

    // Wishbone classic master request
    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
    } busReq_t;

endpackage

// File: design/instrDecoder.sv
`timescale 1ns/10ps

module instrDecoder import ctrlPkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  opcode_t       opcode,
    input  funct_t        funct,
    input  logic          latchDecode,
    output decodedInstr_t decoded
);

    decodedInstr_t classified;
    decodedInstr_t held;

    always_comb begin
        classified.cls  = ClassUnknown;
        classified.size = SizeNone;
        case (opcode)
            OpLw: begin
                classified.cls  = ClassLoad;
                classified.size = SizeWord;
            end
            OpLh: begin
                classified.cls  = ClassLoad;
                classified.size = SizeHalf;
            end
            OpLb: begin
                classified.cls  = ClassLoad;
                classified.size = SizeByte;
            end
            OpSw: begin
                classified.cls  = ClassStore;
                classified.size = SizeWord;
            end
            OpSh: begin
                classified.cls  = ClassStore;
                classified.size = SizeHalf;
            end
            OpSb: begin
                classified.cls  = ClassStore;
                classified.size = SizeByte;
            end
            OpLui: classified.cls = ClassLui;
            // Only break survives among the R-type codes
            OpRType: begin
                if (funct == FunctBreak) begin
                    classified.cls = ClassBreak;
                end
            end
            default: classified.cls = ClassUnknown;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            held <= '{cls: ClassUnknown, size: SizeNone};
        end else if (latchDecode) begin
            held <= classified;
        end
    end

    // Live class during decode, held copy afterwards
    assign decoded = latchDecode ? classified : held;

endmodule

// File: design/mipsControl.sv
`timescale 1ns/10ps

module mipsControl import ctrlPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  opcode_t   opcode,
    input  funct_t    funct,
    input  logic      memAck,
    output ctrlWord_t ctrl,
    output busReq_t   bus
);

    decodedInstr_t decoded;
    step_t         step;
    logic          latchDecode;

    instrDecoder decoder (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode),
        .funct       (funct),
        .latchDecode (latchDecode),
        .decoded     (decoded)
    );

    // Only block that watches the bus acknowledge
    stepSequencer sequencer (
        .clk         (clk),
        .reset       (reset),
        .memAck      (memAck),
        .decoded     (decoded),
        .step        (step),
        .latchDecode (latchDecode)
    );

    controlWordGen wordGen (
        .clk     (clk),
        .reset   (reset),
        .step    (step),
        .decoded (decoded),
        .ctrl    (ctrl),
        .bus     (bus)
    );

endmodule

// File: design/stepSequencer.sv
`timescale 1ns/10ps

module stepSequencer import ctrlPkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          memAck,
    input  decodedInstr_t decoded,
    output step_t         step,
    output logic          latchDecode
);

    // Step whose control word is on the outputs this cycle
    step_t stepQ;
    // Init word already issued once since reset
    logic  initIssued;

    assign latchDecode = (stepQ == StepDecode);

    // step is the word to register at the coming edge
    always_comb begin
        step = stepQ;
        case (stepQ)
            StepInit: begin
                if (initIssued) begin
                    step = StepFetchBus;
                end
            end
            StepFetchBus: begin
                if (memAck) begin
                    step = StepIrLoad;
                end
            end
            StepIrLoad: begin
                step = StepDecode;
            end
            StepDecode: begin
                case (decoded.cls)
                    ClassLoad,
                    ClassStore: step = StepAddrCalc;
                    ClassLui:   step = StepWriteback;
                    ClassBreak: step = StepBreakCalc;
                    default:    step = StepFetchBus;
                endcase
            end
            StepAddrCalc: begin
                if (decoded.cls == ClassLoad) begin
                    step = StepDataRead;
                end else if (decoded.cls == ClassStore) begin
                    step = StepDataWrite;
                end else begin
                    step = StepFetchBus;
                end
            end
            StepDataRead: begin
                if (memAck) begin
                    step = StepWriteback;
                end
            end
            StepDataWrite: begin
                if (memAck) begin
                    step = StepFetchBus;
                end
            end
            StepWriteback: begin
                step = StepFetchBus;
            end
            StepBreakCalc: begin
                step = StepBreakPc;
            end
            StepBreakPc: begin
                step = StepFetchBus;
            end
            default: begin
                step = StepFetchBus;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stepQ      <= StepInit;
            initIssued <= 1'b0;
        end else begin
            stepQ      <= step;
            initIssued <= 1'b1;
        end
    end

endmodule

// File: src.f
design/ctrlPkg.sv
design/instrDecoder.sv
design/stepSequencer.sv
design/controlWordGen.sv
design/mipsControl.sv
verif/mipsControlAsserts.sv
verif/mipsControlTb.sv

// File: verif/ctrlStimulus.txt
// opcode funct fetchDelay dataDelay class size, all hex
// class: 0 load, 1 store, 2 lui, 3 break, 4 unknown; size: 0 none, 1 word, 2 byte, 3 half
23 0D 00 01 0 1
21 00 02 00 0 3
20 00 01 03 0 2
2B 00 00 00 1 1
29 00 03 02 1 3
28 00 01 01 1 2
0F 00 00 00 2 0
00 0D 02 00 3 0
08 00 01 00 4 0
00 20 00 00 4 0
04 00 02 00 4 0
0F 00 04 00 2 0
2B 00 05 04 1 1
23 00 01 05 0 1
00 0D 00 00 3 0
// end of list
FF 00 00 00 0 0

// File: verif/mipsControlAsserts.sv
`timescale 1ns/10ps

module mipsControlAsserts import ctrlPkg::*; (
    input logic      clk,
    input logic      reset,
    input step_t     step,
    input ctrlWord_t ctrl,
    input busReq_t   bus
);

    int failCount = 0;

    // Step that produced the word now on ctrl and bus
    step_t lastStep;
    logic  waiting;

    always_ff @(posedge clk) begin
        if (reset) begin
            lastStep <= StepInit;
        end else begin
            lastStep <= step;
        end
    end

    // Sequencer keeps its step until ack
    assign waiting = bus.stb && (step == lastStep);

    strobeNeedsCycle: assert property (@(posedge clk) disable iff (reset) bus.stb |-> bus.cyc)
        else begin
            $error("stb high without cyc");
            failCount++;
        end

    writeNeedsStrobe: assert property (@(posedge clk) disable iff (reset) bus.we |-> bus.stb)
        else begin
            $error("we high outside a bus cycle");
            failCount++;
        end

    requestHeld: assert property (@(posedge clk) disable iff (reset)
        waiting |=> bus.stb && $stable(bus.we) && $stable(ctrl.iorD))
        else begin
            $error("bus request changed before ack");
            failCount++;
        end

    irNotWithReg: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.irWrite && ctrl.regWrite))
        else begin
            $error("irWrite and regWrite in the same cycle");
            failCount++;
        end

endmodule

bind controlWordGen mipsControlAsserts checks (
    .clk   (clk),
    .reset (reset),
    .step  (step),
    .ctrl  (ctrl),
    .bus   (bus)
);

// File: verif/mipsControlTb.sv
`timescale 1ns/10ps

module mipsControlTb import ctrlPkg::*; ();

    localparam int FieldsPerLine = 6;
    localparam int MaxEntries    = 80;
    localparam int MaxWait       = 64;

    logic      clk;
    logic      reset;
    opcode_t   opcode;
    funct_t    funct;
    logic      memAck;
    ctrlWord_t ctrl;
    busReq_t   bus;

    // opcode, funct, fetch delay, data delay, class, size for each instruction
    logic [7:0] stim [0:511];

    mipsControl UUT (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),
        .funct  (funct),
        .memAck (memAck),
        .ctrl   (ctrl),
        .bus    (bus)
    );

    always #2 clk = ~clk;

    task automatic reportMismatch(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic abortRun(input string reason);
        $display("Run aborted at %0t ns: %s", $time, reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped after an error");
    endtask

    function automatic logic [7:0] field(input int entry, input int column);
        logic [8:0] addr;
        addr = 9'(entry * FieldsPerLine + column);
        return stim[addr];
    endfunction

    // Outputs settled, inputs driven 1 ns after the edge
    task automatic nextCycle();
        @(posedge clk);
        #1;
        assert (UUT.wordGen.checks.failCount == 0)
            else abortRun("a bound bus or control word assertion failed");
    endtask

    // Strobe held for delay extra cycles, then one ack cycle
    task automatic answerStrobe(input int delay, input logic we);
        int waited;
        waited = 0;
        while (waited < delay) begin
            assert (bus.stb && bus.cyc && bus.we == we)
                else reportMismatch("bus request changed before acknowledge");
            nextCycle();
            waited++;
        end
        assert (bus.stb && bus.cyc) else reportMismatch("strobe dropped before acknowledge");
        memAck = 1'b1;
        nextCycle();
        memAck = 1'b0;
    endtask

    task automatic runInstruction(input int entry);
        instrClass_t expClass;
        memSize_t    expSize;
        int          dataDelay;
        int          cycles;
        int          reads;
        int          writes;
        int          regWrites;
        int          pcWrites;
        logic        ok;
        expClass  = instrClass_t'(3'(field(entry, 4)));
        expSize   = memSize_t'(2'(field(entry, 5)));
        dataDelay = int'(field(entry, 3));
        reads     = 0;
        writes    = 0;
        regWrites = 0;
        pcWrites  = 0;
        cycles    = 0;

        assert (bus.stb && !bus.we && ctrl.iorD == IorDPc)
            else reportMismatch("fetch request missing or malformed");
        answerStrobe(int'(field(entry, 2)), 1'b0);
        // New instruction word appears after the fetch ack
        opcode = 6'(field(entry, 0));
        funct  = 6'(field(entry, 1));
        assert (ctrl.irWrite && ctrl.pcWrite && !bus.stb)
            else reportMismatch("irWrite and pcWrite not raised after fetch ack");
        nextCycle();
        assert (!ctrl.irWrite && !ctrl.pcWrite && ctrl.regAWrite && ctrl.regBWrite
                && ctrl.aluOutWrite && ctrl.aluSrcB == SrcBShiftedImm)
            else reportMismatch("decode word wrong or IR load longer than one cycle");
        nextCycle();
        // Instruction register free to change once decoded
        opcode = ~opcode;
        funct  = ~funct;

        while (!(bus.stb && ctrl.iorD == IorDPc)) begin
            assert (cycles < MaxWait) else abortRun("timed out waiting for the next fetch");
            cycles++;
            if (bus.stb) begin
                assert (ctrl.iorD == IorDAluOut)
                    else reportMismatch("data bus cycle without AluOut address");
                if (bus.we) begin
                    writes++;
                    assert (ctrl.storeSize == expSize)
                        else reportMismatch($sformatf("store size %0d, expected %0d",
                            ctrl.storeSize, expSize));
                end else begin
                    reads++;
                end
                answerStrobe(dataDelay, bus.we);
            end else begin
                if (ctrl.regWrite) begin
                    regWrites++;
                    assert (ctrl.regDst == DstRt) else reportMismatch("writeback not to rt");
                    if (expClass == ClassLui) begin
                        assert (ctrl.dataSrc == DataUpperImm)
                            else reportMismatch("lui writeback without upper immediate");
                    end else begin
                        assert (ctrl.dataSrc == DataMemory && ctrl.loadSize == expSize)
                            else reportMismatch($sformatf("load source %0d size %0d, expected %0d",
                                ctrl.dataSrc, ctrl.loadSize, expSize));
                    end
                end
                if (ctrl.pcWrite) begin
                    pcWrites++;
                    assert (ctrl.aluOp == AluSub && ctrl.aluSrcA == SrcAPc
                            && ctrl.aluSrcB == SrcBFour)
                        else reportMismatch("PC rewrite is not PC minus four");
                end
                nextCycle();
            end
        end

        case (expClass)
            ClassLoad:  ok = reads == 1 && writes == 0 && regWrites == 1 && pcWrites == 0;
            ClassStore: ok = reads == 0 && writes == 1 && regWrites == 0 && pcWrites == 0;
            ClassLui:   ok = reads == 0 && writes == 0 && regWrites == 1 && pcWrites == 0;
            ClassBreak: ok = reads == 0 && writes == 0 && regWrites == 0 && pcWrites == 1;
            default:    ok = reads == 0 && writes == 0 && regWrites == 0 && pcWrites == 0;
        endcase
        assert (ok) else reportMismatch($sformatf(
            "entry %0d made %0d reads, %0d writes, %0d reg writes, %0d PC writes",
            entry, reads, writes, regWrites, pcWrites));
    endtask

    initial begin
        int entries;
        clk    = 1'b0;
        reset  = 1'b1;
        opcode = '0;
        funct  = '0;
        memAck = 1'b0;
        $readmemh("verif/ctrlStimulus.txt", stim);
        entries = 0;
        // Opcode FF ends the list
        while (entries < MaxEntries && field(entries, 0) !== 8'hFF
               && !$isunknown(field(entries, 0))) begin
            entries++;
        end
        assert (entries > 0) else abortRun("stimulus file holds no instructions");

        repeat (2) nextCycle();
        assert (ctrl == '0 && bus == '0) else reportMismatch("outputs active during reset");
        reset = 1'b0;
        nextCycle();
        assert (ctrl.regWrite && ctrl.regDst == DstStackPtr && ctrl.dataSrc == DataStackInit
                && !bus.cyc && !bus.stb)
            else reportMismatch("first word after reset is not the init step");
        nextCycle();
        assert (bus.cyc && bus.stb && !bus.we && !ctrl.regWrite)
            else reportMismatch("no fetch right after init");

        for (int i = 0; i < entries; i++) begin
            runInstruction(i);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
